/* files.f */
+incdir+include
hw/player_pkg.sv
hw/input_sampler.sv
hw/motion_fsm.sv
hw/body_physics.sv
hw/sprite_hit.sv
hw/player_top.sv
dv/player_checker.sv
dv/player_tb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the player testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module player_tb -f files.f -o player_sim > build.log 2>&1 \
    && ./obj_dir/player_sim +verilator+error+limit+100 > sim.log 2>&1

grep -qsx "Test completed successfully" sim.log \
    && echo "simulation passed" \
    || { echo "simulation did not pass, see build.log and sim.log"; exit 1; }

/* dv/player_tb.sv */
`include "player_defs.svh"

module player_tb
    import player_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_ROWS = 18;

    typedef struct {
        logic [7:0] keycode;
        logic       alive;
        int         frames;
        coord_t     draw_x;
        coord_t     draw_y;
        int         exp_x;
        int         exp_y;
        int         exp_air;
        int         exp_on;
        int         exp_min_y;
    } row_t;

    logic       Clk;
    logic       rst_n;
    logic       frame_clk;
    logic [7:0] keycode;
    logic       alive;
    coord_t     draw_x;
    coord_t     draw_y;
    coord_t     pos_x;
    coord_t     pos_y;
    logic       in_air;
    logic       sprite_on;

    row_t  rows[NUM_ROWS];
    string names[NUM_ROWS];
    int    num_rows;
    int    errors;
    int    assert_fails;
    int    min_y;
    logic  timed_out;

    player_top u_dut (
        .Clk       (Clk),
        .rst_n     (rst_n),
        .frame_clk (frame_clk),
        .keycode   (keycode),
        .alive     (alive),
        .draw_x    (draw_x),
        .draw_y    (draw_y),
        .pos_x     (pos_x),
        .pos_y     (pos_y),
        .in_air    (in_air),
        .sprite_on (sprite_on)
    );

    always #2 Clk = ~Clk;

    task automatic add_row(input string name, input logic [7:0] key, input logic live,
                           input int frames, input int dx, input int dy, input int ex,
                           input int ey, input int eair, input int eon, input int emin);
        row_t r;
        r.keycode   = key;
        r.alive     = live;
        r.frames    = frames;
        r.draw_x    = coord_t'(dx);
        r.draw_y    = coord_t'(dy);
        r.exp_x     = ex;
        r.exp_y     = ey;
        r.exp_air   = eair;
        r.exp_on    = eon;
        r.exp_min_y = emin;
        rows[num_rows]  = r;
        names[num_rows] = name;
        num_rows++;
    endtask

    // velocity moves the position one tick late
    task automatic load_table();
        num_rows = 0;
        add_row("reset",      8'h00,      1'b1, 1,  90,  400, 80,  384, 0, 1, 384);
        add_row("run_right",  `KEY_RIGHT, 1'b1, 30, 137, 384, 137, 384, 0, 1, 384);
        add_row("stop_right", 8'h00,      1'b1, 20, 176, 390, 144, 384, 0, 0, 384);
        add_row("run_left",   `KEY_LEFT,  1'b1, 64, 0,   384, 0,   384, 0, 1, 384);
        add_row("left_edge",  `KEY_LEFT,  1'b1, 16, 32,  384, 0,   384, 0, 0, 384);
        add_row("stop_left",  8'h00,      1'b1, 4,  0,   383, 0,   384, 0, 0, 384);
        add_row("step_right", `KEY_RIGHT, 1'b1, 5,  3,   416, 3,   384, 0, 1, 384);
        add_row("coast",      8'h00,      1'b1, 4,  5,   417, 5,   384, 0, 0, 384);
        add_row("jump_press", `KEY_JUMP,  1'b1, 1,  5,   384, 5,   384, 0, 1, 384);
        add_row("jump_rise",  8'h00,      1'b1, 10, 36,  285, 5,   285, 1, 1, 285);
        add_row("jump_land",  8'h00,      1'b1, 30, 37,  384, 5,   384, 0, 0, 264);
        add_row("jump_held",  `KEY_JUMP,  1'b1, 40, 5,   384, 5,   384, 0, 1, 264);
        add_row("no_rejump",  `KEY_JUMP,  1'b1, 20, 4,   384, 5,   384, 0, 0, 384);
        add_row("jump_off",   8'h00,      1'b1, 2,  5,   384, 5,   384, 0, 1, 384);
        add_row("death_rise", `KEY_RIGHT, 1'b0, 10, 5,   285, 5,   285, 1, 1, 285);
        add_row("death_fall", `KEY_LEFT,  1'b0, 40, 5,   479, 5,   479, 0, 1, 264);
        add_row("dead_keys",  `KEY_JUMP,  1'b0, 10, 5,   478, 5,   479, 0, 0, 479);
        add_row("stay_dead",  `KEY_RIGHT, 1'b1, 8,  6,   479, 5,   479, 0, 1, 479);
    endtask

    task automatic check_value(input string name, input string field, input int expected,
                               input int actual);
        if (expected != actual)
        begin
            errors++;
            $display("ERR %s %s: expected %0d, actual %0d", name, field, expected, actual);
        end
    endtask

    // frame_clk high for 8 cycles then low for 8
    task automatic run_frame(input int row, input logic load);
        int   c;
        logic tick_seen;
        tick_seen = 1'b0;
        for (c = 0; c < 16; c++)
        begin
            @(posedge Clk);
            if (c == 0)
            begin
                frame_clk <= 1'b1;
                if (load)
                begin
                    keycode <= rows[row].keycode;
                    alive   <= rows[row].alive;
                    draw_x  <= rows[row].draw_x;
                    draw_y  <= rows[row].draw_y;
                end
            end
            else if (c == 8)
                frame_clk <= 1'b0;
            @(negedge Clk);
            if (u_dut.frame_tick)
                tick_seen = 1'b1;
        end
        if (!tick_seen)
        begin
            errors++;
            timed_out = 1'b1;
            $display("timeout: no frame tick seen during a frame of row %s", names[row]);
        end
    endtask

    task automatic apply_row(input int row);
        int f;
        min_y = 1 << `COORD_W;
        for (f = 0; f < rows[row].frames && !timed_out; f++)
        begin
            run_frame(row, f == 0);
            if (int'(pos_y) < min_y)
                min_y = int'(pos_y);
        end
        if (!timed_out)
        begin
            check_value(names[row], "pos_x", rows[row].exp_x, int'(pos_x));
            check_value(names[row], "pos_y", rows[row].exp_y, int'(pos_y));
            check_value(names[row], "in_air", rows[row].exp_air, int'(in_air));
            check_value(names[row], "sprite_on", rows[row].exp_on, int'(sprite_on));
            check_value(names[row], "min_y", rows[row].exp_min_y, min_y);
        end
    endtask

    initial
    begin
        int i;
        Clk       = 1'b0;
        rst_n     = 1'b0;
        frame_clk = 1'b0;
        keycode   = 8'h00;
        alive     = 1'b1;
        draw_x    = '0;
        draw_y    = '0;
        errors    = 0;
        timed_out = 1'b0;
        load_table();

        repeat (5) @(posedge Clk);
        rst_n <= 1'b1;

        for (i = 0; i < num_rows && !timed_out; i++)
            apply_row(i);

        assert_fails = u_dut.u_checker.tick_fails + u_dut.u_checker.range_fails +
                       u_dut.u_checker.hold_fails;
        $display("result: %0d check errors, %0d assertion failures", errors, assert_fails);
        if (errors == 0 && assert_fails == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

/* dv/player_checker.sv */
`include "player_defs.svh"

module player_checker
    import player_pkg::*;
(
    input logic   Clk,
    input logic   rst_n,
    input logic   frame_tick,
    input coord_t pos_x,
    input coord_t pos_y
);

    timeunit 1ns;
    timeprecision 100ps;

    int tick_fails = 0;
    int range_fails = 0;
    int hold_fails = 0;

    // tick is a single cycle pulse
    tick_single: assert property (@(posedge Clk) disable iff (!rst_n)
        frame_tick |=> !frame_tick)
    else
    begin
        tick_fails++;
        $error("frame tick stayed high for two cycles");
    end

    y_in_range: assert property (@(posedge Clk) disable iff (!rst_n)
        pos_y <= coord_t'(`Y_MAX))
    else
    begin
        range_fails++;
        $error("pos_y is below the last screen row");
    end

    // position only moves on a frame tick
    pos_held: assert property (@(posedge Clk) disable iff (!rst_n)
        !frame_tick |=> ($stable(pos_x) && $stable(pos_y)))
    else
    begin
        hold_fails++;
        $error("position changed without a frame tick");
    end

endmodule

bind player_top player_checker u_checker (
    .Clk        (Clk),
    .rst_n      (rst_n),
    .frame_tick (frame_tick),
    .pos_x      (pos_x),
    .pos_y      (pos_y)
);

/* hw/player_top.sv */
module player_top
    import player_pkg::*;
(
    input  logic       Clk,
    input  logic       rst_n,
    input  logic       frame_clk,
    input  logic [7:0] keycode,
    input  logic       alive,
    input  coord_t     draw_x,
    input  coord_t     draw_y,
    output coord_t     pos_x,
    output coord_t     pos_y,
    output logic       in_air,
    output logic       sprite_on
);

    logic frame_tick;
    logic key_left;
    logic key_right;
    logic key_jump;
    vel_t vel_x;
    vel_t vel_y;
    logic dead;

    input_sampler u_input_sampler (
        .Clk        (Clk),
        .rst_n      (rst_n),
        .frame_clk  (frame_clk),
        .keycode    (keycode),
        .frame_tick (frame_tick),
        .key_left   (key_left),
        .key_right  (key_right),
        .key_jump   (key_jump)
    );

    motion_fsm u_motion_fsm (
        .Clk        (Clk),
        .rst_n      (rst_n),
        .frame_tick (frame_tick),
        .key_left   (key_left),
        .key_right  (key_right),
        .key_jump   (key_jump),
        .alive      (alive),
        .pos_x      (pos_x),
        .pos_y      (pos_y),
        .in_air     (in_air),
        .vel_x      (vel_x),
        .vel_y      (vel_y),
        .dead       (dead)
    );

    body_physics u_body_physics (
        .Clk        (Clk),
        .rst_n      (rst_n),
        .frame_tick (frame_tick),
        .vel_x      (vel_x),
        .vel_y      (vel_y),
        .dead       (dead),
        .pos_x      (pos_x),
        .pos_y      (pos_y),
        .in_air     (in_air)
    );

    sprite_hit u_sprite_hit (
        .Clk        (Clk),
        .rst_n      (rst_n),
        .draw_x     (draw_x),
        .draw_y     (draw_y),
        .pos_x      (pos_x),
        .pos_y      (pos_y),
        .sprite_on  (sprite_on)
    );

endmodule

/* hw/sprite_hit.sv */
`include "player_defs.svh"

module sprite_hit
    import player_pkg::*;
(
    input  logic   Clk,
    input  logic   rst_n,
    input  coord_t draw_x,
    input  coord_t draw_y,
    input  coord_t pos_x,
    input  coord_t pos_y,
    output logic   sprite_on
);

    logic [`COORD_W:0] x_end;
    logic [`COORD_W:0] y_end;

    assign x_end = {1'b0, pos_x} + (`COORD_W+1)'(`SPRITE_SIZE);
    assign y_end = {1'b0, pos_y} + (`COORD_W+1)'(`SPRITE_SIZE);

    // right edge exclusive, bottom edge inclusive
    always_ff @(posedge Clk or negedge rst_n)
    begin
        if (!rst_n)
            sprite_on <= 1'b0;
        else
            sprite_on <= (draw_x >= pos_x) && ({1'b0, draw_x} < x_end) &&
                         (draw_y >= pos_y) && ({1'b0, draw_y} <= y_end);
    end

endmodule

/* hw/body_physics.sv */
`include "player_defs.svh"

module body_physics
    import player_pkg::*;
(
    input  logic   Clk,
    input  logic   rst_n,
    input  logic   frame_tick,
    input  vel_t   vel_x,
    input  vel_t   vel_y,
    input  logic   dead,
    output coord_t pos_x,
    output coord_t pos_y,
    output logic   in_air
);

    logic signed [`COORD_W:0] y_sum;

    // one extra bit so the sum cannot wrap past the top
    assign y_sum  = $signed({1'b0, pos_y}) + (`COORD_W+1)'(vel_y);
    assign in_air = y_sum < (`COORD_W+1)'(`GROUND_Y);

    always_ff @(posedge Clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pos_x <= coord_t'(`START_X);
            pos_y <= coord_t'(`GROUND_Y);
        end
        else if (frame_tick)
        begin
            // two's complement add also moves left
            pos_x <= pos_x + coord_t'(vel_x);
            if (dead && y_sum >= (`COORD_W+1)'(`Y_MAX))
                pos_y <= coord_t'(`Y_MAX);
            else if (in_air || dead)
                pos_y <= coord_t'(y_sum);
            else
                pos_y <= coord_t'(`GROUND_Y);
        end
    end

endmodule

/* hw/motion_fsm.sv */
`include "player_defs.svh"

module motion_fsm
    import player_pkg::*;
(
    input  logic   Clk,
    input  logic   rst_n,
    input  logic   frame_tick,
    input  logic   key_left,
    input  logic   key_right,
    input  logic   key_jump,
    input  logic   alive,
    input  coord_t pos_x,
    input  coord_t pos_y,
    input  logic   in_air,
    output vel_t   vel_x,
    output vel_t   vel_y,
    output logic   dead
);

    motion_state_e state;
    motion_state_e state_nx;
    motion_state_e run_up;
    vel_t          vel_x_nx;
    vel_t          vel_y_nx;
    vel_t          run_vel;
    logic          dead_nx;
    logic [3:0]    run_cnt;
    logic [3:0]    run_cnt_nx;
    logic          jump_latch;
    logic          jump_latch_nx;
    logic          run_right;
    logic          run_key;
    logic          speed3;

    logic [`COORD_W:0]        x_right;
    logic signed [`COORD_W:0] x_left;
    logic signed [`COORD_W:0] y_sum;

    assign x_right = {1'b0, pos_x} + (`COORD_W+1)'(`SPRITE_SIZE);
    assign x_left  = $signed({1'b0, pos_x}) + (`COORD_W+1)'(vel_x);
    assign y_sum   = $signed({1'b0, pos_y}) + (`COORD_W+1)'(vel_y);

    assign run_right = state inside {RUN1_R, RUN2_R, RUN3_R};
    assign run_key   = run_right ? key_right : key_left;
    assign speed3    = state inside {RUN3_R, RUN3_L};

    // speed of the current run state and the one above it
    always_comb
    begin
        case (state)
            RUN1_R:  run_vel = vel_t'(1);
            RUN2_R:  run_vel = vel_t'(2);
            RUN3_R:  run_vel = vel_t'(3);
            RUN1_L:  run_vel = vel_t'(-1);
            RUN2_L:  run_vel = vel_t'(-2);
            RUN3_L:  run_vel = vel_t'(-3);
            default: run_vel = '0;
        endcase
        case (state)
            RUN1_R:  run_up = RUN2_R;
            RUN2_R:  run_up = RUN3_R;
            RUN1_L:  run_up = RUN2_L;
            RUN2_L:  run_up = RUN3_L;
            default: run_up = state;
        endcase
    end

    always_comb
    begin
        state_nx      = state;
        vel_x_nx      = vel_x;
        vel_y_nx      = vel_y;
        dead_nx       = dead;
        run_cnt_nx    = run_cnt;
        jump_latch_nx = jump_latch;
        if (!key_jump)
            jump_latch_nx = 1'b0;

        case (state)
            STAND:
            begin
                vel_x_nx   = '0;
                vel_y_nx   = '0;
                run_cnt_nx = '0;
                if (key_jump && !jump_latch)
                    state_nx = JUMP;
                else if (key_left)
                    state_nx = RUN1_L;
                else if (key_right)
                    state_nx = RUN1_R;
            end
            RUN1_R, RUN2_R, RUN3_R, RUN1_L, RUN2_L, RUN3_L:
            begin
                vel_x_nx = run_vel;
                vel_y_nx = '0;
                // stop at the screen edges
                if (run_right && x_right >= (`COORD_W+1)'(`X_RIGHT_LIMIT))
                    vel_x_nx = '0;
                if (!run_right && x_left <= (`COORD_W+1)'(`X_LEFT_LIMIT))
                    vel_x_nx = '0;
                if (key_jump && !jump_latch)
                begin
                    state_nx   = JUMP;
                    run_cnt_nx = '0;
                end
                else if (!run_key)
                begin
                    state_nx   = speed3 ? (run_right ? RUN1_R : RUN1_L) : STAND;
                    run_cnt_nx = '0;
                end
                else if (!speed3)
                begin
                    if (run_cnt == 4'(`RUN_STEP_FRAMES))
                    begin
                        state_nx   = run_up;
                        run_cnt_nx = '0;
                    end
                    else
                        run_cnt_nx = run_cnt + 4'd1;
                end
            end
            JUMP:
            begin
                vel_y_nx      = vel_t'(-`JUMP_SPEED);
                jump_latch_nx = 1'b1;
                state_nx      = AIR;
            end
            AIR:
            begin
                if (in_air)
                begin
                    vel_y_nx = vel_y + vel_t'(1);
                    // bounce off the top of the screen
                    if (y_sum < (`COORD_W+1)'(5))
                        vel_y_nx = -vel_y;
                end
                else
                begin
                    state_nx = LAND;
                    vel_y_nx = '0;
                end
            end
            LAND:
            begin
                run_cnt_nx = '0;
                case (vel_x)
                    vel_t'(1):  state_nx = RUN1_R;
                    vel_t'(2):  state_nx = RUN2_R;
                    vel_t'(3):  state_nx = RUN3_R;
                    vel_t'(-1): state_nx = RUN1_L;
                    vel_t'(-2): state_nx = RUN2_L;
                    vel_t'(-3): state_nx = RUN3_L;
                    default:    state_nx = STAND;
                endcase
            end
            DEAD:
            begin
                // gravity, held short of signed wrap
                if (vel_y < vel_t'(`Y_MAX))
                    vel_y_nx = vel_y + vel_t'(1);
            end
            default:
                state_nx = STAND;
        endcase

        if (!alive && state != DEAD)
        begin
            state_nx = DEAD;
            vel_x_nx = '0;
            vel_y_nx = vel_t'(-`JUMP_SPEED);
            dead_nx  = 1'b1;
        end
    end

    always_ff @(posedge Clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state      <= STAND;
            vel_x      <= '0;
            vel_y      <= '0;
            dead       <= 1'b0;
            run_cnt    <= '0;
            jump_latch <= 1'b0;
        end
        else if (frame_tick)
        begin
            state      <= state_nx;
            vel_x      <= vel_x_nx;
            vel_y      <= vel_y_nx;
            dead       <= dead_nx;
            run_cnt    <= run_cnt_nx;
            jump_latch <= jump_latch_nx;
        end
    end

endmodule

/* hw/input_sampler.sv */
`include "player_defs.svh"

module input_sampler
(
    input  logic       Clk,
    input  logic       rst_n,
    input  logic       frame_clk,
    input  logic [7:0] keycode,
    output logic       frame_tick,
    output logic       key_left,
    output logic       key_right,
    output logic       key_jump
);

    logic frame_sync1;
    logic frame_sync2;
    logic frame_prev;

    // two flop sync, then rising edge into a one cycle tick
    always_ff @(posedge Clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            frame_sync1 <= 1'b0;
            frame_sync2 <= 1'b0;
            frame_prev  <= 1'b0;
            frame_tick  <= 1'b0;
        end
        else
        begin
            frame_sync1 <= frame_clk;
            frame_sync2 <= frame_sync1;
            frame_prev  <= frame_sync2;
            frame_tick  <= frame_sync2 & ~frame_prev;
        end
    end

    // keycode holds one code, so at most one key is set
    always_ff @(posedge Clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            key_left  <= 1'b0;
            key_right <= 1'b0;
            key_jump  <= 1'b0;
        end
        else
        begin
            key_left  <= (keycode == `KEY_LEFT);
            key_right <= (keycode == `KEY_RIGHT);
            key_jump  <= (keycode == `KEY_JUMP);
        end
    end

endmodule

/* hw/player_pkg.sv */
`include "player_defs.svh"

package player_pkg;

    // unsigned pixel position
    typedef logic [`COORD_W-1:0] coord_t;

    // pixels per frame, negative is up or left
    typedef logic signed [`COORD_W-1:0] vel_t;

    typedef enum logic [3:0] {
        STAND,
        RUN1_R,
        RUN2_R,
        RUN3_R,
        RUN1_L,
        RUN2_L,
        RUN3_L,
        JUMP,
        AIR,
        LAND,
        DEAD
    } motion_state_e;

endpackage

/* include/player_defs.svh */
`ifndef PLAYER_DEFS_SVH
`define PLAYER_DEFS_SVH

// screen coordinates
`define COORD_W 10

// start position and ground row, which is also the reset y
`define START_X 80
`define GROUND_Y 384

// lowest visible row where a dying fall ends
`define Y_MAX 479

// horizontal limits for running
`define X_RIGHT_LIMIT 639
`define X_LEFT_LIMIT 1

// character box
`define SPRITE_SIZE 32

// motion
`define JUMP_SPEED 15
`define RUN_STEP_FRAMES 8

// keyboard scan codes
`define KEY_LEFT 8'h04
`define KEY_RIGHT 8'h07
`define KEY_JUMP 8'h1A

`endif
